// ==== source/zx_ula_macros.svh ====
`ifndef ZX_ULA_MACROS_SVH
`define ZX_ULA_MACROS_SVH

// Mixer sum and DAC accumulator width.
`define ZX_DAC_WIDTH 10

// Port FE answers to any even address.
`define ZX_PORT_FE_MASK 16'h0001

// Low address byte of the other ports.
`define ZX_PORT_KEMPSTON 8'h1F
`define ZX_PORT_COVOX    8'hFB
`define ZX_PORT_SD_L0    8'h0F
`define ZX_PORT_SD_L1    8'h1F
`define ZX_PORT_SD_R0    8'h4F
`define ZX_PORT_SD_R1    8'h5F

// Mixer weights of the one-bit sources.
`define ZX_LVL_BEEPER   10'd128
`define ZX_LVL_TAPE_OUT 10'd32
`define ZX_LVL_TAPE_IN  10'd32

`endif

// ==== source/zx_pkg.sv ====
`default_nettype none

package zx_pkg;

    // Sampled Z80 bus with single-cycle I/O strobes.
    typedef struct packed {
        logic [15:0] a;
        logic [7:0]  d;
        logic        io_rd;   // One pulse per I/O read cycle.
        logic        io_wr;   // One pulse per I/O write cycle.
        logic        ioreq;   // High for the whole I/O cycle.
        logic        m1;
    } cpu_bus_t;

    typedef enum logic [1:0] {
        PANNING_STEREO = 2'd0,
        PANNING_MONO   = 2'd1
    } panning_t;

    typedef struct packed {
        logic     covox_en;
        logic     soundrive_en;
        panning_t panning;
    } ula_cfg_t;

    // Four 8-bit digital sound channels, two per side.
    typedef struct packed {
        logic [7:0] l0;
        logic [7:0] l1;
        logic [7:0] r0;
        logic [7:0] r1;
    } sd_channels_t;

    typedef struct packed {
        logic [2:0] border;
        logic       tape_out;
        logic       beeper;
    } port_fe_t;

    // Ordered so bit 0 is right, as on the Kempston port.
    typedef struct packed {
        logic fire;
        logic up;
        logic down;
        logic left;
        logic right;
    } joy_t;

endpackage

`default_nettype wire

// ==== source/bus_capture.sv ====
`default_nettype none

module bus_capture (
    input  wire              clk28,
    input  wire              rst_n,
    input  wire [15:0]       a,
    input  wire [7:0]        d_in,
    input  wire              iorq_n,
    input  wire              rd_n,
    input  wire              wr_n,
    input  wire              m1_n,
    output zx_pkg::cpu_bus_t bus
);

    logic [15:0] a_s;
    logic [7:0]  d_s;
    logic        iorq_s;
    logic        rd_s;
    logic        wr_s;
    logic        m1_s;
    logic        io_cycle;
    logic        rd_seen;
    logic        wr_seen;

    // First stage on the falling edge, strobes turned active high.
    always_ff @(negedge clk28 or negedge rst_n) begin
        if (!rst_n) begin
            a_s    <= '0;
            d_s    <= '0;
            iorq_s <= 1'b0;
            rd_s   <= 1'b0;
            wr_s   <= 1'b0;
            m1_s   <= 1'b0;
        end else begin
            a_s    <= a;
            d_s    <= d_in;
            iorq_s <= ~iorq_n;
            rd_s   <= ~rd_n;
            wr_s   <= ~wr_n;
            m1_s   <= ~m1_n;
        end
    end

    assign io_cycle = iorq_s & ~m1_s; // Interrupt acknowledge excluded.

    always_ff @(posedge clk28 or negedge rst_n) begin
        if (!rst_n) begin
            bus     <= '0;
            rd_seen <= 1'b0;
            wr_seen <= 1'b0;
        end else begin
            bus.a     <= a_s;
            bus.d     <= d_s;
            bus.m1    <= m1_s;
            bus.ioreq <= io_cycle;
            bus.io_rd <= io_cycle & rd_s & ~rd_seen;
            bus.io_wr <= io_cycle & wr_s & ~wr_seen;
            rd_seen   <= io_cycle & rd_s;
            wr_seen   <= io_cycle & wr_s;
        end
    end

endmodule

`default_nettype wire

// ==== source/ports.sv ====
`default_nettype none

`include "zx_ula_macros.svh"

module ports (
    input  wire              clk28,
    input  wire              rst_n,
    input  wire zx_pkg::cpu_bus_t bus,
    input  wire [4:0]        kd,
    input  wire zx_pkg::joy_t joy,
    input  wire              tape_in,
    output zx_pkg::port_fe_t fe,
    output logic [7:0]       kb_addr,
    output logic [7:0]       d_out,
    output logic             d_out_active
);

    logic       fe_hit;
    logic       kempston_hit;
    logic       read_hit;
    logic [7:0] fe_rd_data;
    logic [7:0] kempston_rd_data;

    assign fe_hit       = (bus.a & `ZX_PORT_FE_MASK) == 16'h0000;
    assign kempston_hit = bus.a[7:0] == `ZX_PORT_KEMPSTON;
    assign read_hit     = fe_hit | kempston_hit;

    // Keyboard half-rows are selected by the high address byte.
    assign kb_addr = bus.a[15:8];

    assign fe_rd_data = {1'b1, tape_in, 1'b1, kd};

    assign kempston_rd_data = {
        3'b000,
        joy.fire,
        joy.up,
        joy.down,
        joy.left,
        joy.right
    };

    // Port FE write.
    always_ff @(posedge clk28 or negedge rst_n) begin
        if (!rst_n) begin
            fe <= '0;
        end else if (bus.io_wr && fe_hit) begin
            fe.border   <= bus.d[2:0];
            fe.tape_out <= bus.d[3];
            fe.beeper   <= bus.d[4];
        end
    end

    // Read data is latched once per cycle, at the read strobe.
    always_ff @(posedge clk28 or negedge rst_n) begin
        if (!rst_n) begin
            d_out <= '0;
        end else if (bus.io_rd) begin
            if (fe_hit)
                d_out <= fe_rd_data;
            else if (kempston_hit)
                d_out <= kempston_rd_data;
        end
    end

    // Drive the bus from the strobe until the I/O cycle ends.
    always_ff @(posedge clk28 or negedge rst_n) begin
        if (!rst_n)
            d_out_active <= 1'b0;
        else
            d_out_active <= read_hit & (bus.io_rd | (d_out_active & bus.ioreq));
    end

endmodule

`default_nettype wire

// ==== source/soundrive.sv ====
`default_nettype none

`include "zx_ula_macros.svh"

module soundrive (
    input  wire                  clk28,
    input  wire                  rst_n,
    input  wire zx_pkg::cpu_bus_t bus,
    input  wire zx_pkg::ula_cfg_t cfg,
    output zx_pkg::sd_channels_t ch
);

    logic covox_wr;
    logic sd_wr;
    logic sd_l0_wr;
    logic sd_l1_wr;
    logic sd_r0_wr;
    logic sd_r1_wr;

    assign covox_wr = bus.io_wr & cfg.covox_en & (bus.a[7:0] == `ZX_PORT_COVOX);
    assign sd_wr    = bus.io_wr & cfg.soundrive_en;

    assign sd_l0_wr = sd_wr & (bus.a[7:0] == `ZX_PORT_SD_L0);
    assign sd_l1_wr = sd_wr & (bus.a[7:0] == `ZX_PORT_SD_L1);
    assign sd_r0_wr = sd_wr & (bus.a[7:0] == `ZX_PORT_SD_R0);
    assign sd_r1_wr = sd_wr & (bus.a[7:0] == `ZX_PORT_SD_R1);

    // Covox is a single DAC, so it fills every channel.
    always_ff @(posedge clk28 or negedge rst_n) begin
        if (!rst_n) begin
            ch <= '0;
        end else if (covox_wr) begin
            ch.l0 <= bus.d;
            ch.l1 <= bus.d;
            ch.r0 <= bus.d;
            ch.r1 <= bus.d;
        end else begin
            if (sd_l0_wr)
                ch.l0 <= bus.d;
            if (sd_l1_wr)
                ch.l1 <= bus.d;
            if (sd_r0_wr)
                ch.r0 <= bus.d;
            if (sd_r1_wr)
                ch.r1 <= bus.d;
        end
    end

endmodule

`default_nettype wire

// ==== source/mixer.sv ====
`default_nettype none

`include "zx_ula_macros.svh"

module mixer (
    input  wire                         clk28,
    input  wire                         rst_n,
    input  wire zx_pkg::port_fe_t       fe,
    input  wire                         tape_in,
    input  wire zx_pkg::sd_channels_t   ch,
    input  wire zx_pkg::panning_t       panning,
    output logic [`ZX_DAC_WIDTH-1:0]    level_l,
    output logic [`ZX_DAC_WIDTH-1:0]    level_r
);

    import zx_pkg::*;

    localparam int W = `ZX_DAC_WIDTH;

    logic [W-1:0] beeper_lvl;
    logic [W-1:0] tape_out_lvl;
    logic [W-1:0] tape_in_lvl;
    logic [W-1:0] common;
    logic [W-1:0] sum_l;
    logic [W-1:0] sum_r;
    logic [W:0]   sum_both;
    logic [W-1:0] mono;

    assign beeper_lvl   = fe.beeper   ? `ZX_LVL_BEEPER   : '0;
    assign tape_out_lvl = fe.tape_out ? `ZX_LVL_TAPE_OUT : '0;
    assign tape_in_lvl  = tape_in     ? `ZX_LVL_TAPE_IN  : '0;

    // One-bit sources are heard equally on both sides.
    assign common = beeper_lvl + tape_out_lvl + tape_in_lvl;

    // Peak is 192 + 2 * 255 = 702, well inside 10 bits.
    assign sum_l = common + {{(W-8){1'b0}}, ch.l0} + {{(W-8){1'b0}}, ch.l1};
    assign sum_r = common + {{(W-8){1'b0}}, ch.r0} + {{(W-8){1'b0}}, ch.r1};

    assign sum_both = {1'b0, sum_l} + {1'b0, sum_r};
    assign mono     = sum_both[W:1]; // Halved, rounded down.

    always_ff @(posedge clk28 or negedge rst_n) begin
        if (!rst_n) begin
            level_l <= '0;
            level_r <= '0;
        end else if (panning == PANNING_MONO) begin
            level_l <= mono;
            level_r <= mono;
        end else begin
            level_l <= sum_l;
            level_r <= sum_r;
        end
    end

endmodule

`default_nettype wire

// ==== source/sigma_delta_dac.sv ====
`default_nettype none

`include "zx_ula_macros.svh"

module sigma_delta_dac (
    input  wire                      clk28,
    input  wire                      rst_n,
    input  wire [`ZX_DAC_WIDTH-1:0]  level,
    output logic                     dout
);

    logic [`ZX_DAC_WIDTH-1:0] acc;
    logic [`ZX_DAC_WIDTH:0]   acc_next;

    // The carry out of the accumulator is the output bit.
    assign acc_next = {1'b0, acc} + {1'b0, level};

    always_ff @(posedge clk28 or negedge rst_n) begin
        if (!rst_n) begin
            acc  <= '0;
            dout <= 1'b0;
        end else begin
            acc  <= acc_next[`ZX_DAC_WIDTH-1:0];
            dout <= acc_next[`ZX_DAC_WIDTH]; // Density is level / 1024.
        end
    end

endmodule

`default_nettype wire

// ==== source/zx_ula.sv ====
`default_nettype none

`include "zx_ula_macros.svh"

module zx_ula (
    input  wire                   clk28,
    input  wire                   rst_n,
    input  wire [15:0]            a,
    input  wire [7:0]             d_in,
    input  wire                   iorq_n,
    input  wire                   rd_n,
    input  wire                   wr_n,
    input  wire                   m1_n,
    input  wire [4:0]             kd,
    input  wire zx_pkg::joy_t     joy,
    input  wire                   tape_in,
    input  wire zx_pkg::ula_cfg_t cfg,
    output logic [7:0]            d_out,
    output logic                  d_oe,
    output logic [7:0]            kb_addr,
    output logic [2:0]            border,
    output logic                  tape_out,
    output logic                  snd_l,
    output logic                  snd_r
);

    import zx_pkg::*;

    cpu_bus_t                 bus;
    port_fe_t                 fe;
    sd_channels_t             ch;
    logic                     ports_d_out_active;
    logic [`ZX_DAC_WIDTH-1:0] level_l;
    logic [`ZX_DAC_WIDTH-1:0] level_r;

    bus_capture u_bus_capture (
        .clk28(clk28),
        .rst_n(rst_n),
        .a(a),
        .d_in(d_in),
        .iorq_n(iorq_n),
        .rd_n(rd_n),
        .wr_n(wr_n),
        .m1_n(m1_n),
        .bus(bus)
    );

    ports u_ports (
        .clk28(clk28),
        .rst_n(rst_n),
        .bus(bus),
        .kd(kd),
        .joy(joy),
        .tape_in(tape_in),
        .fe(fe),
        .kb_addr(kb_addr),
        .d_out(d_out),
        .d_out_active(ports_d_out_active)
    );

    soundrive u_soundrive (
        .clk28(clk28),
        .rst_n(rst_n),
        .bus(bus),
        .cfg(cfg),
        .ch(ch)
    );

    mixer u_mixer (
        .clk28(clk28),
        .rst_n(rst_n),
        .fe(fe),
        .tape_in(tape_in),
        .ch(ch),
        .panning(cfg.panning),
        .level_l(level_l),
        .level_r(level_r)
    );

    sigma_delta_dac u_dac_l (
        .clk28(clk28),
        .rst_n(rst_n),
        .level(level_l),
        .dout(snd_l)
    );

    sigma_delta_dac u_dac_r (
        .clk28(clk28),
        .rst_n(rst_n),
        .level(level_r),
        .dout(snd_r)
    );

    assign d_oe     = ports_d_out_active; // Only the port block answers reads.
    assign border   = fe.border;
    assign tape_out = fe.tape_out;

endmodule

`default_nettype wire

// ==== verif/zx_ula_tb_table.svh ====
// Columns: op, random data, address, data, cfg {covox_en, soundrive_en, panning},
// kd, joy {fire, up, down, left, right}, tape_in, expected read data, expected d_oe.
task automatic load_table();
    add_row(OP_COUNT, 1'b0, 16'h0000, 8'h00, 4'h0, 5'h00, 5'h00, 1'b0, 8'h00, 1'b0);
    // Border 5 with tape out on.
    add_row(OP_WRITE, 1'b0, 16'h00FE, 8'h0D, 4'h0, 5'h00, 5'h00, 1'b0, 8'h00, 1'b0);
    add_row(OP_COUNT, 1'b0, 16'h0000, 8'h00, 4'h0, 5'h00, 5'h00, 1'b1, 8'h00, 1'b0);
    add_row(OP_READ,  1'b0, 16'h7FFE, 8'h00, 4'h0, 5'h15, 5'h00, 1'b1, 8'hF5, 1'b1);
    add_row(OP_READ,  1'b0, 16'hFEFE, 8'h00, 4'h0, 5'h0A, 5'h00, 1'b0, 8'hAA, 1'b1);
    add_row(OP_READ,  1'b0, 16'h001F, 8'h00, 4'h0, 5'h1F, 5'h16, 1'b0, 8'h16, 1'b1);
    add_row(OP_READ,  1'b0, 16'h00FD, 8'h00, 4'h0, 5'h1F, 5'h1F, 1'b0, 8'h00, 1'b0);
    add_row(OP_WRITE, 1'b1, 16'h00FE, 8'h00, 4'h0, 5'h00, 5'h00, 1'b0, 8'h00, 1'b0);
    add_row(OP_WRITE, 1'b1, 16'h01FE, 8'h00, 4'h0, 5'h00, 5'h00, 1'b0, 8'h00, 1'b0);
    add_row(OP_COUNT, 1'b0, 16'h0000, 8'h00, 4'h0, 5'h00, 5'h00, 1'b0, 8'h00, 1'b0);
    add_row(OP_WRITE, 1'b0, 16'h00FE, 8'h00, 4'h0, 5'h00, 5'h00, 1'b0, 8'h00, 1'b0);
    // Soundrive channels with the enable set.
    add_row(OP_WRITE, 1'b0, 16'h000F, 8'h40, 4'h4, 5'h00, 5'h00, 1'b0, 8'h00, 1'b0);
    add_row(OP_WRITE, 1'b0, 16'h001F, 8'h21, 4'h4, 5'h00, 5'h00, 1'b0, 8'h00, 1'b0);
    add_row(OP_WRITE, 1'b0, 16'h004F, 8'h80, 4'h4, 5'h00, 5'h00, 1'b0, 8'h00, 1'b0);
    add_row(OP_WRITE, 1'b0, 16'h005F, 8'h3C, 4'h4, 5'h00, 5'h00, 1'b0, 8'h00, 1'b0);
    add_row(OP_COUNT, 1'b0, 16'h0000, 8'h00, 4'h4, 5'h00, 5'h00, 1'b0, 8'h00, 1'b0);
    // Same ports with the enables clear.
    add_row(OP_WRITE, 1'b0, 16'h000F, 8'hFF, 4'h0, 5'h00, 5'h00, 1'b0, 8'h00, 1'b0);
    add_row(OP_WRITE, 1'b0, 16'h005F, 8'hFF, 4'h0, 5'h00, 5'h00, 1'b0, 8'h00, 1'b0);
    add_row(OP_WRITE, 1'b0, 16'h00FB, 8'hFF, 4'h4, 5'h00, 5'h00, 1'b0, 8'h00, 1'b0);
    add_row(OP_COUNT, 1'b0, 16'h0000, 8'h00, 4'h4, 5'h00, 5'h00, 1'b0, 8'h00, 1'b0);
    // Covox, beeper and mono panning.
    add_row(OP_WRITE, 1'b0, 16'h00FB, 8'h55, 4'h8, 5'h00, 5'h00, 1'b0, 8'h00, 1'b0);
    add_row(OP_WRITE, 1'b0, 16'h00FE, 8'h10, 4'h8, 5'h00, 5'h00, 1'b0, 8'h00, 1'b0);
    add_row(OP_COUNT, 1'b0, 16'h0000, 8'h00, 4'h9, 5'h00, 5'h00, 1'b0, 8'h00, 1'b0);
    add_row(OP_WRITE, 1'b0, 16'h004F, 8'h03, 4'hD, 5'h00, 5'h00, 1'b0, 8'h00, 1'b0);
    add_row(OP_COUNT, 1'b0, 16'h0000, 8'h00, 4'hD, 5'h00, 5'h00, 1'b0, 8'h00, 1'b0);
    add_row(OP_COUNT, 1'b0, 16'h0000, 8'h00, 4'hC, 5'h00, 5'h00, 1'b1, 8'h00, 1'b0);
    add_row(OP_WRITE, 1'b1, 16'h000F, 8'h00, 4'h4, 5'h00, 5'h00, 1'b0, 8'h00, 1'b0);
    add_row(OP_WRITE, 1'b1, 16'h005F, 8'h00, 4'h4, 5'h00, 5'h00, 1'b0, 8'h00, 1'b0);
    add_row(OP_COUNT, 1'b0, 16'h0000, 8'h00, 4'h5, 5'h00, 5'h00, 1'b0, 8'h00, 1'b0);
    add_row(OP_WRITE, 1'b1, 16'h00FB, 8'h00, 4'hC, 5'h00, 5'h00, 1'b0, 8'h00, 1'b0);
    add_row(OP_COUNT, 1'b0, 16'h0000, 8'h00, 4'h8, 5'h00, 5'h00, 1'b1, 8'h00, 1'b0);
endtask

// ==== verif/zx_ula_tb.sv ====
`default_nettype none

`include "zx_ula_macros.svh"

module zx_ula_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import zx_pkg::*;

    localparam logic [1:0] OP_WRITE = 2'd0;
    localparam logic [1:0] OP_READ  = 2'd1;
    localparam logic [1:0] OP_COUNT = 2'd2;
    localparam int         WINDOW   = 1 << `ZX_DAC_WIDTH;

    typedef struct packed {
        logic [1:0]  op;
        logic        rnd;      // Data comes from the LCG.
        logic [15:0] addr;
        logic [7:0]  data;
        logic [3:0]  cfg;
        logic [4:0]  kd;
        logic [4:0]  joy;
        logic        tape_in;
        logic [7:0]  exp_d;
        logic        exp_oe;
    } row_t;

    logic        clk28;
    logic        rst_n;
    logic [15:0] a;
    logic [7:0]  d_in;
    logic        iorq_n;
    logic        rd_n;
    logic        wr_n;
    logic        m1_n;
    logic [4:0]  kd;
    joy_t        joy;
    logic        tape_in;
    ula_cfg_t    cfg;
    logic [7:0]  d_out;
    logic        d_oe;
    logic [7:0]  kb_addr;
    logic [2:0]  border;
    logic        tape_out;
    logic        snd_l;
    logic        snd_r;

    row_t        rows [$];
    bit          table_loaded;
    int          errors;
    int          checks;
    logic [31:0] lcg_state;

    // Expected state of the border and the sound sources.
    logic [2:0]  m_border;
    logic        m_tape_out;
    logic        m_beeper;
    logic [7:0]  m_l0;
    logic [7:0]  m_l1;
    logic [7:0]  m_r0;
    logic [7:0]  m_r1;

    initial clk28 = 1'b0;
    always #5 clk28 = ~clk28;

    zx_ula u_dut (
        .clk28(clk28),
        .rst_n(rst_n),
        .a(a),
        .d_in(d_in),
        .iorq_n(iorq_n),
        .rd_n(rd_n),
        .wr_n(wr_n),
        .m1_n(m1_n),
        .kd(kd),
        .joy(joy),
        .tape_in(tape_in),
        .cfg(cfg),
        .d_out(d_out),
        .d_oe(d_oe),
        .kb_addr(kb_addr),
        .border(border),
        .tape_out(tape_out),
        .snd_l(snd_l),
        .snd_r(snd_r)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("ERROR %s: got 'h%0h, expected 'h%0h at %0t", name, got, expected, $time);
        end
    endtask

    task automatic add_row(input logic [1:0] op, input logic rnd, input logic [15:0] addr,
                           input logic [7:0] data, input logic [3:0] cfg_bits,
                           input logic [4:0] kd_bits, input logic [4:0] joy_bits,
                           input logic tape, input logic [7:0] exp_d, input logic exp_oe);
        row_t r;
        r.op      = op;
        r.rnd     = rnd;
        r.addr    = addr;
        r.data    = data;
        r.cfg     = cfg_bits;
        r.kd      = kd_bits;
        r.joy     = joy_bits;
        r.tape_in = tape;
        r.exp_d   = exp_d;
        r.exp_oe  = exp_oe;
        rows.push_back(r);
    endtask

    `include "zx_ula_tb_table.svh"

    // Port FE sits on even addresses. Covox and Soundrive use their low bytes.
    task automatic update_model(input logic [15:0] addr, input logic [7:0] data,
                                input logic [3:0] cfg_bits);
        if (addr[0] == 1'b0) begin
            m_border   = data[2:0];
            m_tape_out = data[3];
            m_beeper   = data[4];
        end
        if (cfg_bits[3] && addr[7:0] == `ZX_PORT_COVOX) begin
            m_l0 = data;
            m_l1 = data;
            m_r0 = data;
            m_r1 = data;
        end
        if (cfg_bits[2]) begin
            case (addr[7:0])
                `ZX_PORT_SD_L0: m_l0 = data;
                `ZX_PORT_SD_L1: m_l1 = data;
                `ZX_PORT_SD_R0: m_r0 = data;
                `ZX_PORT_SD_R1: m_r1 = data;
                default: ;
            endcase
        end
    endtask

    function automatic int side_level(input logic [7:0] c0, input logic [7:0] c1,
                                      input logic tape);
        int lvl;
        lvl = int'(c0) + int'(c1);
        if (m_beeper)
            lvl += int'(`ZX_LVL_BEEPER);
        if (m_tape_out)
            lvl += int'(`ZX_LVL_TAPE_OUT);
        if (tape)
            lvl += int'(`ZX_LVL_TAPE_IN);
        return lvl;
    endfunction

    task automatic io_write(input logic [15:0] addr, input logic [7:0] data);
        @(negedge clk28);
        a      <= addr;
        d_in   <= data;
        iorq_n <= 1'b0;
        wr_n   <= 1'b0;
        repeat (3) @(negedge clk28);
        iorq_n <= 1'b1;
        wr_n   <= 1'b1;
        @(negedge clk28);
    endtask

    task automatic io_read(input logic [15:0] addr, output logic [7:0] data,
                           output logic [7:0] high, output logic seen);
        int i;
        seen = 1'b0;
        @(negedge clk28);
        a      <= addr;
        iorq_n <= 1'b0;
        rd_n   <= 1'b0;
        for (i = 0; i < 3 && !seen; i++) begin
            @(negedge clk28);
            seen = d_oe;
        end
        data   = d_out;
        high   = kb_addr;
        iorq_n <= 1'b1;
        rd_n   <= 1'b1;
        i = 0;
        do begin
            @(negedge clk28);
            i++;
        end while (d_oe && i < 6);
        check_value("d_oe after read", 32'(d_oe), 32'h0);
    endtask

    task automatic count_ones(output int ones_l, output int ones_r);
        ones_l = 0;
        ones_r = 0;
        repeat (4) @(negedge clk28); // Mixer and DAC pick up the new level.
        repeat (WINDOW) begin
            @(negedge clk28);
            if (snd_l)
                ones_l++;
            if (snd_r)
                ones_r++;
        end
    endtask

    initial begin
        row_t       row;
        logic [7:0] data;
        logic [7:0] rd_data;
        logic [7:0] rd_high;
        logic       seen;
        int         ones_l;
        int         ones_r;
        int         exp_l;
        int         exp_r;

        rst_n   <= 1'b0;
        a       <= '0;
        d_in    <= '0;
        iorq_n  <= 1'b1;
        rd_n    <= 1'b1;
        wr_n    <= 1'b1;
        m1_n    <= 1'b1;
        kd      <= '0;
        joy     <= '0;
        tape_in <= 1'b0;
        cfg     <= '0;
        errors     = 0;
        checks     = 0;
        lcg_state  = 32'h3e0f_ab99;
        m_border   = '0;
        m_tape_out = 1'b0;
        m_beeper   = 1'b0;
        m_l0       = '0;
        m_l1       = '0;
        m_r0       = '0;
        m_r1       = '0;
        load_table();
        table_loaded = 1'b1;

        repeat (4) @(negedge clk28);
        rst_n <= 1'b1;
        @(negedge clk28);
        check_value("border", 32'(border), 32'h0);
        check_value("tape_out", 32'(tape_out), 32'h0);
        check_value("d_oe", 32'(d_oe), 32'h0);

        foreach (rows[i]) begin
            row  = rows[i];
            data = row.data;
            if (row.rnd) begin
                lcg_state = lcg_next(lcg_state);
                data      = lcg_state[23:16];
            end
            @(negedge clk28);
            cfg     <= ula_cfg_t'(row.cfg);
            kd      <= row.kd;
            joy     <= joy_t'(row.joy);
            tape_in <= row.tape_in;
            case (row.op)
                OP_WRITE: begin
                    io_write(row.addr, data);
                    update_model(row.addr, data, row.cfg);
                    check_value("border", 32'(border), 32'(m_border));
                    check_value("tape_out", 32'(tape_out), 32'(m_tape_out));
                end
                OP_READ: begin
                    io_read(row.addr, rd_data, rd_high, seen);
                    check_value("d_oe", 32'(seen), 32'(row.exp_oe));
                    if (row.exp_oe) begin
                        check_value("d_out", 32'(rd_data), 32'(row.exp_d));
                        check_value("kb_addr", 32'(rd_high), 32'(row.addr[15:8]));
                    end
                end
                default: begin
                    count_ones(ones_l, ones_r);
                    exp_l = side_level(m_l0, m_l1, row.tape_in);
                    exp_r = side_level(m_r0, m_r1, row.tape_in);
                    if (row.cfg[1:0] == PANNING_MONO) begin
                        exp_l = (exp_l + exp_r) / 2;
                        exp_r = exp_l;
                    end
                    check_value("snd_l ones", ones_l, exp_l);
                    check_value("snd_r ones", ones_r, exp_r);
                end
            endcase
        end

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

    // Every row fits in one DAC window plus a bus cycle.
    initial begin
        longint limit_ns;
        wait (table_loaded);
        limit_ns = longint'(rows.size()) * (8 + WINDOW) * 10 + 2000;
        #(limit_ns);
        $display("Timeout: the run did not finish within %0d ns", limit_ns);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== zx_ula.f ====
+incdir+source
+incdir+verif
source/zx_pkg.sv
source/bus_capture.sv
source/ports.sv
source/soundrive.sv
source/mixer.sv
source/sigma_delta_dac.sv
source/zx_ula.sv
verif/zx_ula_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = zx_ula_tb
FILELIST  = zx_ula.f
OBJ_DIR   = obj_dir
BIN       = $(OBJ_DIR)/V$(TOP)
LOG       = sim.log
SOURCES   = $(wildcard source/*.sv source/*.svh verif/*.sv verif/*.svh)

.PHONY: all run check clean

all: check

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)

check: run
	@if grep -q "Simulation FAILED" $(LOG); then echo "Run reported a failure"; exit 1; fi
	@grep -q "Simulation PASSED" $(LOG) || { echo "No result found in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
